// ==== bench/tb_top.sv ====
module tb_top;

	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////////////////////////
	// raster and run length
	//////////////////////////////////////////////////

	localparam int H_TOTAL = 80;						// pixels per raster line
	localparam int V_TOTAL = 48;						// lines per frame
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;	// 3840
	localparam int NUM_FRAMES = 7;						// 1 + 3 + 1 + 1 + 1 over all tests
	localparam int TIMEOUT = NUM_FRAMES * FRAME_CYCLES + 100;	// reset and drain slack
	localparam int TEXT_W = overlay_pkg::TEXT_BITS;
	localparam int TOTAL_CHARS = overlay_pkg::CHARS_PER_LINE * overlay_pkg::NUM_LINES;

	// test ids, -1 marks idle samples between tests
	localparam int T_RESET = 0;
	localparam int T_BACKGROUND = 1;
	localparam int T_GLYPH = 2;
	localparam int T_SPACING = 3;
	localparam int T_UNKNOWN = 4;
	localparam int T_RESTART = 5;
	localparam int NUM_TESTS = 6;

	// what kind of box pixel a sample is
	localparam int KIND_PLAIN = 0;
	localparam int KIND_DARK = 1;		// margin or spacing column
	localparam int KIND_BADCELL = 2;	// glyph dot of an unsupported code
	localparam int KIND_FIRST = 3;		// glyph dot of cell (0,0)

	`include "font_glyphs.svh"

	typedef struct {
		bit sq;			// expected in_square
		bit ch;			// expected in_character
		int test;
		int kind;
		int h;
		int v;
	} sample_t;

	logic clk;
	logic rst;
	overlay_pkg::coord_t hc;
	overlay_pkg::coord_t vc;
	logic [TEXT_W-1:0] text;
	logic in_square;
	logic in_character;

	int sample_tag;			// test that owns the sample on hc/vc
	bit model_on;
	sample_t pipe_q[$];		// samples still inside the DUT, 2 deep
	int checks;
	int errors;
	int test_checks[NUM_TESTS];
	int test_errs[NUM_TESTS];
	int first_exp;			// lit dots of cell (0,0), model side
	int first_got;
	int cycle_count;
	logic [TEXT_W-1:0] frame_text;

	text_overlay_top i_text_overlay_top (
		.clk (clk),
		.rst (rst),
		.hc (hc),
		.vc (vc),
		.text (text),
		.in_square (in_square),
		.in_character (in_character)
	);

	always #2 clk = ~clk;		// 4 ns period

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic string test_name(input int id);
		case (id)
			T_RESET: return "reset_quiet";
			T_BACKGROUND: return "background";
			T_GLYPH: return "glyph_text";
			T_SPACING: return "spacing_dark";
			T_UNKNOWN: return "unknown_code";
			T_RESTART: return "frame_restart";
			default: return "idle";
		endcase
	endfunction

	task automatic check(input int id, input string what, input int expected, input int actual);
		checks++;
		if (id >= 0)
			test_checks[id]++;
		if (expected != actual)
		begin
			errors++;
			if (id >= 0)
				test_errs[id]++;
			$display("Fail %s %s: expected %0d, actual %0d at %0t",
				test_name(id), what, expected, actual, $time);
		end
	endtask

	// font order: space, then 0-9, then A-F
	function automatic logic [7:0] code_of(input int slot);
		if (slot == 0)
			return 8'h20;
		else if (slot <= 10)
			return 8'h30 + 8'(slot - 1);
		else
			return 8'h41 + 8'(slot - 11);
	endfunction

	function automatic int code_slot(input logic [7:0] code);
		for (int i = 0; i < overlay_pkg::FONT_CODES; i++)
			if (code_of(i) == code)
				return i;
		return -1;		// not in the font
	endfunction

	function automatic logic [7:0] bad_code();
		logic [7:0] code;
		code = 8'($urandom);
		while (code_slot(code) >= 0)
			code = 8'($urandom);
		return code;
	endfunction

	// character 0 sits in the top byte
	function automatic logic [TEXT_W-1:0] put_char(input logic [TEXT_W-1:0] t, input int pos,
		input logic [7:0] code);
		logic [TEXT_W-1:0] mask;
		logic [TEXT_W-1:0] val;
		mask = '0;
		mask[7:0] = 8'hff;
		val = '0;
		val[7:0] = code;
		mask = mask << (8 * (TOTAL_CHARS - 1 - pos));
		val = val << (8 * (TOTAL_CHARS - 1 - pos));
		return (t & ~mask) | val;
	endfunction

	function automatic logic [TEXT_W-1:0] random_text(input int bad_pct);
		logic [TEXT_W-1:0] t;
		t = '0;
		for (int i = 0; i < TOTAL_CHARS; i++)
		begin
			if (int'($urandom_range(99)) < bad_pct)
				t = put_char(t, i, bad_code());
			else
				t = put_char(t, i, code_of(int'($urandom_range(16))));
		end
		return t;
	endfunction

	//////////////////////////////////////////////////
	// reference model of one beam sample
	//////////////////////////////////////////////////

	function automatic sample_t model_sample(input int h, input int v,
		input logic [TEXT_W-1:0] t, input int id);
		sample_t s;
		int rx;
		int ry;
		int sx;
		int sy;
		int col;
		int row;
		int gx;
		int gy;
		int slot;
		logic [7:0] code;
		s.sq = 1'b0;
		s.ch = 1'b0;
		s.test = id;
		s.kind = KIND_PLAIN;
		s.h = h;
		s.v = v;
		rx = 0;
		ry = 0;
		if (h >= int'(overlay_pkg::BOX_X) && h <= int'(overlay_pkg::BOX_X) + overlay_pkg::BOX_W)
			rx = h - int'(overlay_pkg::BOX_X);
		if (v >= int'(overlay_pkg::BOX_Y) && v <= int'(overlay_pkg::BOX_Y) + overlay_pkg::BOX_H)
			ry = v - int'(overlay_pkg::BOX_Y);
		if (rx > 0 && ry > 0)
		begin
			s.sq = 1'b1;
			if (rx <= overlay_pkg::DOT_SCALE || ry <= overlay_pkg::DOT_SCALE)
				s.kind = KIND_DARK;		// top or left margin
			else
			begin
				sx = (rx - overlay_pkg::DOT_SCALE - 1) / overlay_pkg::DOT_SCALE;
				sy = (ry - overlay_pkg::DOT_SCALE - 1) / overlay_pkg::DOT_SCALE;
				col = sx / overlay_pkg::CELL_W;
				gx = sx % overlay_pkg::CELL_W;
				row = sy / overlay_pkg::CELL_H;
				gy = sy % overlay_pkg::CELL_H;
				code = 8'(t >> (8 * (TOTAL_CHARS - 1 - (row * overlay_pkg::CHARS_PER_LINE + col))));
				slot = code_slot(code);
				if (gx >= overlay_pkg::GLYPH_W)
					s.kind = KIND_DARK;			// spacing column
				else if (slot < 0)
					s.kind = KIND_BADCELL;		// unknown code, stays blank
				else
				begin
					s.ch = FONT_ROM[slot][gy][gx];
					if (row == 0 && col == 0)
						s.kind = KIND_FIRST;
				end
			end
		end
		return s;
	endfunction

	//////////////////////////////////////////////////
	// output checker, sampled on the falling edge
	//////////////////////////////////////////////////

	always @(negedge clk)
	begin
		sample_t s;
		if (model_on)
		begin
			if (pipe_q.size() == 2)
			begin
				s = pipe_q.pop_front();		// sample from 2 clocks back
				check(s.test, $sformatf("in_square at (%0d,%0d)", s.h, s.v), s.sq, in_square);
				check(s.test, $sformatf("in_character at (%0d,%0d)", s.h, s.v), s.ch,
					in_character);
				if (s.kind == KIND_DARK && s.test == T_SPACING)
					check(s.test, $sformatf("dark pixel at (%0d,%0d)", s.h, s.v), 0, in_character);
				if (s.kind == KIND_BADCELL && s.test == T_UNKNOWN)
					check(s.test, $sformatf("unknown cell at (%0d,%0d)", s.h, s.v), 0,
						in_character);
				if (s.kind == KIND_FIRST && s.test == T_RESTART)
				begin
					first_exp += int'(s.ch);
					first_got += int'(in_character);
				end
			end
			pipe_q.push_back(model_sample(int'(hc), int'(vc), text, sample_tag));
		end
	end

	// run limit
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("sim failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	// one raster frame, new text goes in at the start of change_line
	task automatic drive_frame(input logic [TEXT_W-1:0] new_text, input int change_line,
		input int id);
		for (int v = 0; v < V_TOTAL; v++)
			for (int h = 0; h < H_TOTAL; h++)
			begin
				@(posedge clk);
				hc <= overlay_pkg::coord_t'(h);
				vc <= overlay_pkg::coord_t'(v);
				sample_tag <= id;
				if (v == change_line && h == 0)
					text <= new_text;		// blanking, outside the box
			end
	endtask

	task automatic end_test(input int id);
		@(posedge clk);
		sample_tag <= -1;			// beam parks outside the box
		repeat (3) @(posedge clk);	// last samples leave the pipeline
		$display("test %-13s %-6s %0d checks, %0d errors", test_name(id),
			(test_errs[id] == 0) ? "ok" : "FAILED", test_checks[id], test_errs[id]);
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		hc = '0;
		vc = '0;
		text = '0;
		sample_tag = T_RESET;
		model_on = 1'b0;
		void'($urandom(31));

		// outputs held low during reset
		repeat (5)
		begin
			@(negedge clk);
			check(T_RESET, "in_square during reset", 0, in_square);
			check(T_RESET, "in_character during reset", 0, in_character);
		end
		@(posedge clk);
		rst <= 1'b0;
		// two reset samples still in flight, both dark
		pipe_q.push_back('{1'b0, 1'b0, T_RESET, KIND_PLAIN, 0, 0});
		pipe_q.push_back('{1'b0, 1'b0, T_RESET, KIND_PLAIN, 0, 0});
		model_on = 1'b1;
		end_test(T_RESET);

		drive_frame(random_text(10), 0, T_BACKGROUND);
		end_test(T_BACKGROUND);

		repeat (3)
			drive_frame(random_text(0), 0, T_GLYPH);	// fresh text each frame
		end_test(T_GLYPH);

		drive_frame(random_text(0), 0, T_SPACING);
		end_test(T_SPACING);

		// at least one unknown code on each line
		frame_text = random_text(25);
		frame_text = put_char(frame_text, 1, bad_code());
		frame_text = put_char(frame_text, 6, bad_code());
		drive_frame(frame_text, 0, T_UNKNOWN);
		end_test(T_UNKNOWN);

		// first cell always shows a glyph, text swapped a few lines into blanking
		first_exp = 0;
		first_got = 0;
		frame_text = put_char(random_text(0), 0, code_of(1 + int'($urandom_range(15))));
		drive_frame(frame_text, 3, T_RESTART);
		check(T_RESTART, "lit dots in first cell", first_exp, first_got);
		check(T_RESTART, "first cell has lit dots", 1, int'(first_got > 0));
		end_test(T_RESTART);

		$display("total %0d checks, %0d errors", checks, errors);
		if (errors == 0 && checks > 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== design/beam_window.sv ====
module beam_window (
	input overlay_pkg::coord_t hc,		// beam column
	input overlay_pkg::coord_t vc,		// beam row
	window_if.win win
);

	logic h_in;		// column within box span
	logic v_in;		// row within box span
	logic edge_col;	// beam on the right box edge
	logic v_body;	// row strictly below the top edge

	//////////////////////////////////////////////////
	// range decode
	//////////////////////////////////////////////////

	assign h_in = (hc >= overlay_pkg::BOX_X) && (hc <= overlay_pkg::BOX_X_END);
	assign v_in = (vc >= overlay_pkg::BOX_Y) && (vc <= overlay_pkg::BOX_Y_END);

	// relative coords, both edges count as 0 on the near side
	assign win.rel_x = h_in ? hc - overlay_pkg::BOX_X : '0;
	assign win.rel_y = v_in ? vc - overlay_pkg::BOX_Y : '0;

	//////////////////////////////////////////////////
	// region flags
	//////////////////////////////////////////////////

	assign win.in_square = (win.rel_x != '0) && (win.rel_y != '0);

	// glyph area starts one scaled dot in from top and left
	assign win.h_active = win.in_square && (win.rel_x > overlay_pkg::MARGIN);
	assign win.v_active = win.rel_y > overlay_pkg::MARGIN;

	// line end taken straight from the screen coords
	assign edge_col = hc == overlay_pkg::BOX_X_END;
	assign v_body = (vc > overlay_pkg::BOX_Y) && (vc <= overlay_pkg::BOX_Y_END);
	assign win.line_end = edge_col && v_body;	// vertical counter steps here

	// two decodes of the same edge have to agree
	always_comb
	begin
		assert (!win.line_end || win.in_square)
			else $error("beam_window: line_end outside the box");
	end

endmodule

// ==== design/cell_tracker.sv ====
module cell_tracker #(
	parameter int CELL = 6,			// dots per cell along this axis
	parameter int COUNT = 4,		// cells along this axis
	parameter bit AXIS_V = 1'b0,	// 1 = rows, steps once per raster line
	localparam int IDX_W = (COUNT > 1) ? $clog2(COUNT) : 1
) (
	input logic clk,
	input logic rst,
	window_if.axis win,
	output logic [IDX_W-1:0] index,							// cell number
	output logic [overlay_pkg::OFFSET_W-1:0] offset,		// dot inside the cell
	output logic active										// sample in glyph area
);

	localparam logic [overlay_pkg::OFFSET_W-1:0] OFFSET_LAST =
		overlay_pkg::OFFSET_W'(CELL - 1);
	localparam logic [IDX_W-1:0] INDEX_LAST = IDX_W'(COUNT - 1);

	logic [overlay_pkg::SCALE_W-1:0] scale_q;		// screen pixels into the dot
	logic [overlay_pkg::SCALE_W-1:0] scale_d;
	logic [overlay_pkg::OFFSET_W-1:0] offset_d;
	logic [IDX_W-1:0] index_d;
	logic run;			// this axis is inside the glyph area
	logic step;			// one screen pixel further on this axis
	logic scale_wrap;
	logic offset_wrap;

	//////////////////////////////////////////////////
	// axis selection
	//////////////////////////////////////////////////

	assign run = AXIS_V ? win.v_active : win.h_active;
	assign step = AXIS_V ? win.line_end : 1'b1;	// columns move every pixel

	assign scale_wrap = scale_q == overlay_pkg::SCALE_LAST;
	assign offset_wrap = offset == OFFSET_LAST;

	// scale -> offset -> index chain
	always_comb
	begin
		scale_d = scale_q;
		offset_d = offset;
		index_d = index;
		if (!run || !active)
		begin
			// outside, or first sample of the area: start at cell 0, dot 0
			scale_d = '0;
			offset_d = '0;
			index_d = '0;
		end
		else if (step)
		begin
			if (!scale_wrap)
				scale_d = scale_q + 1'b1;
			else
			begin
				scale_d = '0;
				if (!offset_wrap)
					offset_d = offset + 1'b1;
				else
				begin
					offset_d = '0;
					// last row steps past the box on its line end, fold back
					index_d = (index == INDEX_LAST) ? '0 : index + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			scale_q <= '0;
			offset <= '0;
			index <= '0;
			active <= 1'b0;
		end
		else
		begin
			scale_q <= scale_d;
			offset <= offset_d;
			index <= index_d;
			active <= run;		// follows the sample just taken
		end
	end

	// counters stay inside the cell grid
	a_in_grid: assert property (@(posedge clk) disable iff (rst)
		active |-> (offset <= OFFSET_LAST) && (index <= INDEX_LAST));

endmodule

// ==== design/glyph_fetch.sv ====
module glyph_fetch (
	input logic clk,
	input logic rst,
	input logic [overlay_pkg::TEXT_BITS-1:0] text,		// line 0 first, first char in top byte
	input logic [overlay_pkg::COL_W-1:0] col,			// character column
	input logic [overlay_pkg::OFFSET_W-1:0] gx,			// dot column inside the cell
	input logic h_act,
	input logic [overlay_pkg::ROW_W-1:0] row,			// text line
	input logic [overlay_pkg::OFFSET_W-1:0] gy,			// glyph row inside the cell
	input logic v_act,
	window_if.out win,
	output logic in_square,
	output logic in_character
);

	`include "font_glyphs.svh"

	int char_num;								// flat character position
	logic [overlay_pkg::TEXT_BITS-1:0] text_sh;	// wanted byte moved to the top
	logic [7:0] code;
	logic [overlay_pkg::FONT_IDX_W-1:0] entry;
	logic dot;
	logic lit;
	logic square_d1;							// background, one stage behind

	//////////////////////////////////////////////////
	// character select
	//////////////////////////////////////////////////

	assign char_num = int'(row) * overlay_pkg::CHARS_PER_LINE + int'(col);
	assign text_sh = text << (8 * char_num);
	assign code = text_sh[overlay_pkg::TEXT_BITS-1 -: 8];

	assign entry = font_entry(code);		// unknown codes give the blank entry

	//////////////////////////////////////////////////
	// dot lookup
	//////////////////////////////////////////////////

	// spacing column has no bit in the table
	assign dot = (gx < overlay_pkg::SPACING_COL) ? FONT_ROM[entry][gy][gx] : 1'b0;

	assign lit = h_act && v_act && dot;	// margins and outside stay dark

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			square_d1 <= 1'b0;
			in_square <= 1'b0;
			in_character <= 1'b0;
		end
		else
		begin
			square_d1 <= win.in_square;		// tracker stage
			in_square <= square_d1;			// output stage
			in_character <= lit;
		end
	end

	// foreground only ever on top of the box
	a_char_in_box: assert property (@(posedge clk) disable iff (rst)
		in_character |-> in_square);

endmodule

// ==== design/overlay_pkg.sv ====
package overlay_pkg;

	//////////////////////////////////////////////////
	// coordinates and box placement
	//////////////////////////////////////////////////

	typedef logic [10:0] coord_t;		// screen or box-relative pixel coordinate

	localparam coord_t BOX_X = 11'd10;	// left edge of the box on screen
	localparam coord_t BOX_Y = 11'd6;	// top edge of the box on screen

	localparam int DOT_SCALE = 2;		// screen pixels per glyph dot, both axes

	//////////////////////////////////////////////////
	// character cell
	//////////////////////////////////////////////////

	localparam int GLYPH_W = 5;			// lit columns of a glyph
	localparam int CELL_W = 6;			// glyph plus one blank column
	localparam int CELL_H = 8;			// rows per cell

	localparam int CHARS_PER_LINE = 4;
	localparam int NUM_LINES = 2;

	// one scaled dot of margin at top and left
	localparam int BOX_W = DOT_SCALE + CELL_W * CHARS_PER_LINE * DOT_SCALE;	// 50
	localparam int BOX_H = DOT_SCALE + CELL_H * NUM_LINES * DOT_SCALE;		// 34

	// last covered pixel, inclusive
	localparam coord_t BOX_X_END = BOX_X + coord_t'(BOX_W);
	localparam coord_t BOX_Y_END = BOX_Y + coord_t'(BOX_H);
	localparam coord_t MARGIN = coord_t'(DOT_SCALE);	// relative coords up to here are margin

	localparam int TEXT_BITS = 8 * CHARS_PER_LINE * NUM_LINES;	// one byte per character

	//////////////////////////////////////////////////
	// counter widths
	//////////////////////////////////////////////////

	localparam int SCALE_W = (DOT_SCALE > 1) ? $clog2(DOT_SCALE) : 1;
	localparam logic [SCALE_W-1:0] SCALE_LAST = SCALE_W'(DOT_SCALE - 1);

	localparam int OFFSET_W = 3;		// dot offset in a cell, 0..7
	localparam logic [OFFSET_W-1:0] SPACING_COL = OFFSET_W'(GLYPH_W);	// first dark column

	localparam int COL_W = (CHARS_PER_LINE > 1) ? $clog2(CHARS_PER_LINE) : 1;
	localparam int ROW_W = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1;

	// font
	localparam int FONT_CODES = 17;		// space, 0-9, A-F
	localparam int FONT_IDX_W = $clog2(FONT_CODES);

endpackage

// ==== design/text_overlay_top.sv ====
module text_overlay_top (
	input logic clk,
	input logic rst,
	input overlay_pkg::coord_t hc,							// beam column
	input overlay_pkg::coord_t vc,							// beam row
	input logic [overlay_pkg::TEXT_BITS-1:0] text,			// characters, line 0 first
	output logic in_square,									// box background
	output logic in_character								// glyph dot
);

	window_if win_bus ();		// combinational decode of the current sample

	// column side of the cell grid
	logic [overlay_pkg::COL_W-1:0] col;
	logic [overlay_pkg::OFFSET_W-1:0] gx;
	logic h_act;

	// row side
	logic [overlay_pkg::ROW_W-1:0] row;
	logic [overlay_pkg::OFFSET_W-1:0] gy;
	logic v_act;

	//////////////////////////////////////////////////
	// stage 0: window decode
	//////////////////////////////////////////////////

	beam_window i_beam_window (
		.hc (hc),
		.vc (vc),
		.win (win_bus)
	);

	//////////////////////////////////////////////////
	// stage 1: cell trackers
	//////////////////////////////////////////////////

	cell_tracker #(
		.CELL (overlay_pkg::CELL_W),
		.COUNT (overlay_pkg::CHARS_PER_LINE),
		.AXIS_V (1'b0)
	) h_tracker (
		.clk (clk),
		.rst (rst),
		.win (win_bus),
		.index (col),
		.offset (gx),
		.active (h_act)
	);

	cell_tracker #(
		.CELL (overlay_pkg::CELL_H),
		.COUNT (overlay_pkg::NUM_LINES),
		.AXIS_V (1'b1)		// once per line
	) v_tracker (
		.clk (clk),
		.rst (rst),
		.win (win_bus),
		.index (row),
		.offset (gy),
		.active (v_act)
	);

	// stage 2: lookup and output register
	glyph_fetch i_glyph_fetch (
		.clk (clk),
		.rst (rst),
		.text (text),
		.col (col),
		.gx (gx),
		.h_act (h_act),
		.row (row),
		.gy (gy),
		.v_act (v_act),
		.win (win_bus),
		.in_square (in_square),
		.in_character (in_character)
	);

endmodule

// ==== design/window_if.sv ====
// beam position decoded against the text box, one sample per clock
interface window_if;

	overlay_pkg::coord_t rel_x;		// hc minus box left edge, 0 outside
	overlay_pkg::coord_t rel_y;		// vc minus box top edge, 0 outside

	logic in_square;		// beam inside the box, background
	logic h_active;			// inside the box and past the left margin
	logic v_active;			// below the top margin, whole raster line
	logic line_end;			// last box pixel of a box line

	// decoder side
	modport win (output rel_x, rel_y, in_square, h_active, v_active, line_end);

	// per-axis counters
	modport axis (input h_active, v_active, line_end);

	// glyph stage only needs the background flag
	modport out (input in_square);

endinterface

// ==== include/font_glyphs.svh ====
// 5x8 glyphs, row 0 on top
// bit 0 of a row is the leftmost dot, so the literals read mirrored
// entry 0 is the space and doubles as the blank for unknown codes

localparam logic [0:7][4:0] FONT_ROM [overlay_pkg::FONT_CODES] = '{
	{5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000},	// space
	{5'b01110, 5'b10001, 5'b11001, 5'b10101, 5'b10011, 5'b10001, 5'b01110, 5'b00000},	// 0
	{5'b00100, 5'b00110, 5'b00100, 5'b00100, 5'b00100, 5'b00100, 5'b01110, 5'b00000},	// 1
	{5'b01110, 5'b10001, 5'b10000, 5'b01000, 5'b00100, 5'b00010, 5'b11111, 5'b00000},	// 2
	{5'b11111, 5'b01000, 5'b00100, 5'b01000, 5'b10000, 5'b10001, 5'b01110, 5'b00000},	// 3
	{5'b01000, 5'b01100, 5'b01010, 5'b01001, 5'b11111, 5'b01000, 5'b01000, 5'b00000},	// 4
	{5'b11111, 5'b00001, 5'b01111, 5'b10000, 5'b10000, 5'b10001, 5'b01110, 5'b00000},	// 5
	{5'b01100, 5'b00010, 5'b00001, 5'b01111, 5'b10001, 5'b10001, 5'b01110, 5'b00000},	// 6
	{5'b11111, 5'b10000, 5'b01000, 5'b00100, 5'b00010, 5'b00010, 5'b00010, 5'b00000},	// 7
	{5'b01110, 5'b10001, 5'b10001, 5'b01110, 5'b10001, 5'b10001, 5'b01110, 5'b00000},	// 8
	{5'b01110, 5'b10001, 5'b10001, 5'b11110, 5'b10000, 5'b01000, 5'b00110, 5'b00000},	// 9
	{5'b01110, 5'b10001, 5'b10001, 5'b11111, 5'b10001, 5'b10001, 5'b10001, 5'b00000},	// A
	{5'b01111, 5'b10001, 5'b10001, 5'b01111, 5'b10001, 5'b10001, 5'b01111, 5'b00000},	// B
	{5'b01110, 5'b10001, 5'b00001, 5'b00001, 5'b00001, 5'b10001, 5'b01110, 5'b00000},	// C
	{5'b00111, 5'b01001, 5'b10001, 5'b10001, 5'b10001, 5'b01001, 5'b00111, 5'b00000},	// D
	{5'b11111, 5'b00001, 5'b00001, 5'b01111, 5'b00001, 5'b00001, 5'b11111, 5'b00000},	// E
	{5'b11111, 5'b00001, 5'b00001, 5'b01111, 5'b00001, 5'b00001, 5'b00001, 5'b00000}	// F
};

// ascii code to table entry
function automatic logic [overlay_pkg::FONT_IDX_W-1:0] font_entry(input logic [7:0] code);
	logic [7:0] slot;		// entry before narrowing

	slot = 8'd0;			// space and anything unsupported
	if (code >= 8'h30 && code <= 8'h39)
	begin
		slot = code - 8'h2f;	// '0' lands on entry 1
	end
	else if (code >= 8'h41 && code <= 8'h46)
	begin
		slot = code - 8'h36;	// 'A' lands on entry 11
	end
	return slot[overlay_pkg::FONT_IDX_W-1:0];
endfunction

// ==== run_sim.sh ====
#!/bin/sh
# build the text overlay testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_top_sim \
	&& ./obj_dir/tb_top_sim | tee "$LOG" \
	|| echo "build or simulation error" >> "$LOG"

# only the testbench's own closing line counts
grep -qx "sim passed" "$LOG" && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// ==== tb.f ====
+incdir+include
design/overlay_pkg.sv
design/window_if.sv
design/beam_window.sv
design/cell_tracker.sv
design/glyph_fetch.sv
design/text_overlay_top.sv
bench/tb_top.sv
